//--- all.f
+incdir+include
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/way_store.sv
rtl/way_lookup.sv
rtl/plru_tree.sv
rtl/cache_fsm.sv
rtl/assoc_tuner.sv
rtl/mutative_cache.sv
bench/mutative_cache_checker.sv
bench/tb_mutative_cache.sv

//--- bench/mutative_cache_checker.sv
module mutative_cache_checker (
    input logic                       clk,
    input logic                       rst,
    input cache_geom_pkg::byte_mask_t ufp_rmask,
    input cache_geom_pkg::byte_mask_t ufp_wmask,
    input logic                       ufp_resp,
    input cache_geom_pkg::addr_t      dfp_addr,
    input logic                       dfp_read,
    input logic                       dfp_write,
    input logic                       dfp_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // read by the testbench
    logic        req_held;

    assign req_held = |ufp_rmask || |ufp_wmask;

    no_read_write_overlap: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else begin
            fail_count++;
            $error("dfp_read and dfp_write are high in the same cycle");
        end

    resp_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else begin
            fail_count++;
            $error("ufp_resp stayed high for more than one cycle");
        end

    resp_with_request: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> req_held)
        else begin
            fail_count++;
            $error("ufp_resp came while no request was held");
        end

    // a waiting memory request keeps its strobe and line address
    mem_request_stable: assert property (@(posedge clk) disable iff (rst)
        ((dfp_read || dfp_write) && !dfp_resp) |=> $stable({dfp_read, dfp_write, dfp_addr}))
        else begin
            fail_count++;
            $error("memory request changed before dfp_resp");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!ufp_resp && !dfp_read && !dfp_write))
        else begin
            fail_count++;
            $error("ufp_resp, dfp_read or dfp_write high right after reset");
        end

endmodule

//--- bench/tb_mutative_cache.sv
module tb_mutative_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int RESET_CYCLES     = 4;
    localparam int MEM_LATENCY      = 3;
    localparam int RANDOM_REQS      = 300;
    localparam int TOTAL_REQS       = 12 + 13 + 11 + 11 + RANDOM_REQS;  // tests in run order
    localparam int WORST_REQ_CYCLES = 2 * (MEM_LATENCY + 1) + 5;  // write-back plus refill
    localparam int TIMEOUT_CYCLES   = 2 * (2 * RESET_CYCLES + TOTAL_REQS * WORST_REQ_CYCLES);

    logic        clk;
    logic        rst;
    addr_t       ufp_addr;
    byte_mask_t  ufp_rmask;
    byte_mask_t  ufp_wmask;
    word_t       ufp_wdata;
    word_t       ufp_rdata;
    logic        ufp_resp;
    addr_t       dfp_addr;
    logic        dfp_read;
    logic        dfp_write;
    line_t       dfp_wdata;
    line_t       dfp_rdata;
    logic        dfp_resp;
    assoc_mode_t assoc_mode;

    word_t ref_words [addr_t];  // every cpu write lands here
    word_t mem_words [addr_t];  // backing memory, only written lines
    int    mem_reads;
    addr_t last_wb_addr;
    string current_test;

    mutative_cache i_mutative_cache (.*);

    bind mutative_cache mutative_cache_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t fill_word(addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h6a09_e667;  // bijective in the address
    endfunction

    function automatic word_t ref_word(addr_t addr);
        return ref_words.exists(addr) ? ref_words[addr] : fill_word(addr);
    endfunction

    function automatic word_t mem_word(addr_t addr);
        return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_mask_t mask);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic abort_run(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    task automatic serve_memory();
        addr_t addr;
        for (int w = 0; w < 8; w++) begin
            addr = dfp_addr + addr_t'(4 * w);
            if (dfp_write) begin
                check_value({current_test, " write-back data"}, ref_word(addr),
                            dfp_wdata[w*32 +: 32]);
                mem_words[addr] = dfp_wdata[w*32 +: 32];
            end else begin
                dfp_rdata[w*32 +: 32] = mem_word(addr);
            end
        end
        if (dfp_write) begin
            last_wb_addr = dfp_addr;
        end else begin
            mem_reads++;
        end
    endtask

    // answers each line request after a fixed wait
    initial begin : memory_model
        int wait_cycles;
        wait_cycles = 0;
        forever begin
            @(posedge clk);
            #1;
            dfp_resp = 1'b0;
            if (dfp_read || dfp_write) begin
                wait_cycles++;
                if (wait_cycles == MEM_LATENCY) begin
                    wait_cycles = 0;
                    serve_memory();
                    dfp_resp = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("timeout, the DUT stopped answering requests");
            end
        end
    end

    always @(negedge clk) begin
        if (i_mutative_cache.i_checker.fail_count != 0) begin
            abort_run("a protocol assertion in the checker failed");
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // cycles counts edges from the request to the ufp_resp cycle
    task automatic do_request(input addr_t addr, input byte_mask_t rmask,
                              input byte_mask_t wmask, input word_t wdata,
                              output word_t rdata, output int cycles);
        ufp_addr  = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        cycles    = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ufp_resp);
        rdata = ufp_rdata;
        @(posedge clk);
        #1;
        ufp_rmask = '0;
        ufp_wmask = '0;
    endtask

    task automatic read_check(input addr_t addr, output int cycles);
        word_t rdata;
        do_request(addr, 4'hf, 4'h0, '0, rdata, cycles);
        check_value(current_test, ref_word(addr), rdata);
    endtask

    task automatic write_word(input addr_t addr, input byte_mask_t wmask, input word_t wdata);
        word_t ignored;
        int    cycles;
        do_request(addr, 4'h0, wmask, wdata, ignored, cycles);
        ref_words[addr] = merge_bytes(ref_word(addr), wdata, wmask);
    endtask

    task automatic test_read_after_reset();
        addr_t addr;
        int    cycles;
        current_test = "read_after_reset";
        for (int i = 0; i < 6; i++) begin
            addr = addr_t'((i << 8) | (i << 5) | (i << 2));  // tag i, set i, word i
            read_check(addr, cycles);
            read_check(addr ^ 32'h10, cycles);  // other word, same line
            check_value("read_after_reset latency", 2, cycles);
        end
    endtask

    task automatic test_tuning();
        addr_t line_a;
        addr_t line_b;
        int    reads_before;
        int    cycles;
        current_test = "tuning";
        line_a       = 32'h0000_1020;  // tag 0x10, set 1
        line_b       = 32'h0000_2020;  // tag 0x20, same set and direct way
        for (int i = 0; i < 6; i++) begin
            read_check((i % 2 == 0) ? line_a : line_b, cycles);
            check_value("tuning mode", (i == 5) ? TWO_WAY : DIRECT, assoc_mode);
        end
        read_check(line_a, cycles);  // lands in the second way of the pair
        reads_before = mem_reads;
        for (int i = 0; i < 6; i++) begin
            read_check((i % 2 == 0) ? line_b : line_a, cycles);
            check_value("tuning hit latency", 2, cycles);
        end
        check_value("tuning memory reads", reads_before, mem_reads);
    endtask

    task automatic test_byte_writes();
        addr_t      addr;
        byte_mask_t masks [5];
        int         cycles;
        current_test = "byte_writes";
        masks        = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b1010};
        addr         = 32'h0000_0344;  // tag 3, set 2, word 1
        read_check(addr, cycles);
        foreach (masks[k]) begin
            write_word(addr, masks[k], 32'h1122_3344 + k * 32'h0101_0101);
            read_check(addr, cycles);
        end
    endtask

    task automatic test_write_back();
        addr_t dirty_addr;
        addr_t other;
        int    cycles;
        current_test = "write_back";
        dirty_addr   = 32'h0000_40a8;  // tag 0x40, set 5, word 2
        last_wb_addr = '1;
        write_word(dirty_addr, 4'hf, 32'h1357_9bdf);
        for (int k = 1; k <= 8 && last_wb_addr != (dirty_addr & ~32'h1f); k++) begin
            other = dirty_addr + addr_t'(k * 32'h400);  // same set, same low tag bits
            read_check(other, cycles);
        end
        check_value("write_back address", dirty_addr & ~32'h1f, last_wb_addr);
        read_check(dirty_addr, cycles);
        read_check(dirty_addr ^ 32'h4, cycles);
    endtask

    task automatic test_random_traffic();
        addr_t       addr;
        assoc_mode_t prev_mode;
        int          cycles;
        current_test = "random_traffic";
        prev_mode    = assoc_mode;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            addr = addr_t'(($urandom_range(7) << 8) | ($urandom_range(3) << 5)
                           | ($urandom_range(7) << 2));
            if ($urandom_range(1) == 1) begin
                write_word(addr, byte_mask_t'($urandom_range(15, 1)), $urandom);
            end else begin
                read_check(addr, cycles);
            end
            assert (assoc_mode >= prev_mode) else abort_run("assoc_mode went narrower");
            prev_mode = assoc_mode;
        end
    endtask

    initial begin : main
        void'($urandom(32'h248b3514));
        rst          = 1'b1;
        ufp_addr     = '0;
        ufp_rmask    = '0;
        ufp_wmask    = '0;
        ufp_wdata    = '0;
        dfp_rdata    = '0;
        dfp_resp     = 1'b0;
        mem_reads    = 0;
        last_wb_addr = '1;
        apply_reset();
        test_read_after_reset();
        apply_reset();  // nothing dirty yet, memory still matches
        test_tuning();
        test_byte_writes();
        test_write_back();
        test_random_traffic();
        @(posedge clk);
        #1;
        if (i_mutative_cache.i_checker.fail_count != 0) begin
            abort_run("a protocol assertion in the checker failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define CACHE_WAYS      4   // physical ways per set
`define CACHE_SETS      8
`define LINE_BYTES      32  // one memory burst
`define WORD_BYTES      4   // cpu word
`define ADDR_BITS       32
`define CONFLICT_LIMIT  4   // conflict misses per widening step

`endif

//--- rtl/assoc_tuner.sv
`include "cache_settings.svh"

module assoc_tuner (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lookup,
    input  logic                        hit,
    input  cache_geom_pkg::line_addr_t  line_addr,
    output cache_ctrl_pkg::assoc_mode_t mode
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int SHADOW_N = `CACHE_WAYS * `CACHE_SETS;  // same capacity as the cache
    localparam int PTR_BITS = $clog2(SHADOW_N);
    localparam int CNT_BITS = $clog2(`CONFLICT_LIMIT + 1);

    line_addr_t          shadow_tag [SHADOW_N];
    logic [SHADOW_N-1:0] shadow_valid;
    logic [PTR_BITS-1:0] fifo_ptr;  // oldest entry
    logic [CNT_BITS-1:0] conflict_cnt;
    logic                shadow_hit;
    logic                conflict;

    always_comb begin
        shadow_hit = 1'b0;
        for (int i = 0; i < SHADOW_N; i++) begin
            if (shadow_valid[i] && shadow_tag[i] == line_addr) begin
                shadow_hit = 1'b1;
            end
        end
    end

    // fully associative would have kept it, so the set mapping lost it
    assign conflict = lookup && !hit && shadow_hit;

    always_ff @(posedge clk) begin
        if (lookup && !shadow_hit) begin
            shadow_tag[fifo_ptr] <= line_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow_valid <= '0;
            fifo_ptr     <= '0;
            conflict_cnt <= '0;
            mode         <= DIRECT;
        end else begin
            if (lookup && !shadow_hit) begin
                shadow_valid[fifo_ptr] <= 1'b1;
                fifo_ptr               <= fifo_ptr + 1'b1;  // wraps over all entries
            end
            if (conflict) begin
                if (conflict_cnt == CNT_BITS'(`CONFLICT_LIMIT - 1) && mode != FOUR_WAY) begin
                    mode         <= assoc_mode_t'(mode + 2'd1);  // one step wider
                    conflict_cnt <= '0;
                end else if (conflict_cnt != CNT_BITS'(`CONFLICT_LIMIT)) begin
                    conflict_cnt <= conflict_cnt + 1'b1;  // saturates at the limit
                end
            end
        end
    end

endmodule

//--- rtl/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

    // larger value means wider associativity
    typedef enum logic [1:0] {
        DIRECT   = 2'd0,
        TWO_WAY  = 2'd1,
        FOUR_WAY = 2'd2
    } assoc_mode_t;

endpackage

//--- rtl/cache_fsm.sv
module cache_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,
    input  logic                        is_write,
    input  logic                        hit,
    input  logic                        victim_dirty,
    input  logic                        mem_resp,
    output cache_ctrl_pkg::ctrl_state_t state,
    output logic                        lookup,
    output logic                        cpu_write,
    output logic                        refill_write,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        resp
);
    import cache_ctrl_pkg::*;

    ctrl_state_t next;
    logic        from_idle;  // high in the first COMPARE of a request

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            from_idle <= 1'b0;
        end else begin
            state     <= next;
            from_idle <= (state == IDLE);
        end
    end

    always_comb begin
        next         = state;
        lookup       = 1'b0;
        cpu_write    = 1'b0;
        refill_write = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        resp         = 1'b0;
        case (state)
            IDLE: begin
                if (req) begin
                    next = COMPARE;
                end
            end
            COMPARE: begin
                lookup = from_idle;  // a retry after refill is not counted
                if (hit) begin
                    cpu_write = is_write;
                    next      = RESPOND;
                end else if (victim_dirty) begin
                    next = WRITEBACK;
                end else begin
                    next = REFILL;
                end
            end
            WRITEBACK: begin
                mem_write = 1'b1;
                if (mem_resp) begin
                    next = REFILL;
                end
            end
            REFILL: begin
                mem_read = 1'b1;
                if (mem_resp) begin
                    refill_write = 1'b1;  // line lands in the victim way
                    next         = COMPARE;
                end
            end
            RESPOND: begin
                resp = 1'b1;
                next = IDLE;
            end
            default: next = IDLE;
        endcase
    end

endmodule

//--- rtl/cache_geom_pkg.sv
`include "cache_settings.svh"

package cache_geom_pkg;

    localparam int OFFSET_BITS    = $clog2(`LINE_BYTES);
    localparam int SET_BITS       = $clog2(`CACHE_SETS);
    localparam int TAG_BITS       = `ADDR_BITS - SET_BITS - OFFSET_BITS;
    localparam int WORDS_PER_LINE = `LINE_BYTES / `WORD_BYTES;
    localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);

    typedef logic [`ADDR_BITS-1:0]             addr_t;
    typedef logic [TAG_BITS-1:0]               tag_t;
    typedef logic [SET_BITS-1:0]               set_idx_t;
    typedef logic [WORD_SEL_BITS-1:0]          word_sel_t;
    typedef logic [`LINE_BYTES*8-1:0]          line_t;
    typedef logic [`WORD_BYTES*8-1:0]          word_t;
    typedef logic [`WORD_BYTES-1:0]            byte_mask_t;
    typedef logic [`LINE_BYTES-1:0]            line_mask_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]    way_idx_t;
    typedef logic [`CACHE_WAYS-1:0]            way_vec_t;
    typedef logic [`ADDR_BITS-OFFSET_BITS-1:0] line_addr_t;  // tag and set together

endpackage

//--- rtl/mutative_cache.sv
`include "cache_settings.svh"

module mutative_cache (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_geom_pkg::addr_t       ufp_addr,
    input  cache_geom_pkg::byte_mask_t  ufp_rmask,
    input  cache_geom_pkg::byte_mask_t  ufp_wmask,
    input  cache_geom_pkg::word_t       ufp_wdata,
    output cache_geom_pkg::word_t       ufp_rdata,
    output logic                        ufp_resp,
    output cache_geom_pkg::addr_t       dfp_addr,
    output logic                        dfp_read,
    output logic                        dfp_write,
    output cache_geom_pkg::line_t       dfp_wdata,
    input  cache_geom_pkg::line_t       dfp_rdata,
    input  logic                        dfp_resp,
    output cache_ctrl_pkg::assoc_mode_t assoc_mode
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    addr_t       req_addr;  // held for the whole request
    byte_mask_t  req_wmask;
    word_t       req_wdata;
    assoc_mode_t req_mode;  // mode sampled per request
    set_idx_t    set_idx;
    tag_t        req_tag;
    word_sel_t   word_sel;
    line_t       way_data [`CACHE_WAYS];
    tag_t        way_tag [`CACHE_WAYS];
    way_vec_t    way_valid;
    way_vec_t    way_dirty;
    way_vec_t    group;
    way_vec_t    line_we;
    line_mask_t  line_wmask;
    line_t       line_wdata;
    logic        dirty_wdata;
    logic        hit;
    way_idx_t    hit_way;
    way_idx_t    victim;
    logic        victim_dirty;
    word_t       rdata;
    ctrl_state_t state;
    logic        lookup;
    logic        cpu_write;
    logic        refill_write;
    logic        mem_read;
    logic        mem_write;
    logic        touch;
    way_idx_t    touch_way;

    always_ff @(posedge clk) begin
        if (state == IDLE && (|ufp_rmask || |ufp_wmask)) begin
            req_addr  <= ufp_addr;
            req_wmask <= ufp_wmask;
            req_wdata <= ufp_wdata;
            req_mode  <= assoc_mode;
        end
    end

    assign set_idx  = req_addr[OFFSET_BITS +: SET_BITS];
    assign req_tag  = req_addr[`ADDR_BITS-1 -: TAG_BITS];
    assign word_sel = req_addr[OFFSET_BITS-1 -: WORD_SEL_BITS];

    // refill line or cpu word into the store
    always_comb begin
        line_we     = '0;
        line_wmask  = '0;
        line_wdata  = dfp_rdata;
        dirty_wdata = 1'b0;
        if (refill_write) begin
            line_we[victim] = 1'b1;
            line_wmask      = '1;
        end else if (cpu_write) begin
            line_we[hit_way] = 1'b1;
            line_wmask       = line_mask_t'(req_wmask) << (word_sel * `WORD_BYTES);
            line_wdata       = {WORDS_PER_LINE{req_wdata}};
            dirty_wdata      = 1'b1;
        end
    end

    assign victim_dirty = way_valid[victim] && way_dirty[victim];
    assign touch        = (state == COMPARE && hit) || refill_write;
    assign touch_way    = refill_write ? victim : hit_way;

    assign ufp_rdata = rdata;
    assign dfp_read  = mem_read;
    assign dfp_write = mem_write;
    assign dfp_wdata = way_data[victim];
    assign dfp_addr  = mem_write ? {way_tag[victim], set_idx, {OFFSET_BITS{1'b0}}}
                                 : {req_tag, set_idx, {OFFSET_BITS{1'b0}}};

    way_store i_way_store (
        .tag_wdata (req_tag),
        .*
    );

    way_lookup i_way_lookup (
        .mode (req_mode),
        .*
    );

    plru_tree i_plru_tree (.*);

    cache_fsm i_cache_fsm (
        .req      (|ufp_rmask || |ufp_wmask),
        .is_write (|req_wmask),
        .mem_resp (dfp_resp),
        .resp     (ufp_resp),
        .*
    );

    assoc_tuner i_assoc_tuner (
        .line_addr (req_addr[`ADDR_BITS-1:OFFSET_BITS]),
        .mode      (assoc_mode),
        .*
    );

endmodule

//--- rtl/plru_tree.sv
`include "cache_settings.svh"

module plru_tree (
    input  logic                     clk,
    input  logic                     rst,
    input  cache_geom_pkg::set_idx_t set_idx,
    input  logic                     touch,
    input  cache_geom_pkg::way_idx_t touch_way,
    input  cache_geom_pkg::way_vec_t group,
    output cache_geom_pkg::way_idx_t victim
);
    logic [2:0] tree_q [`CACHE_SETS];  // [0] root, [1] ways 0/1, [2] ways 2/3
    logic [2:0] cur;
    logic       go_right;
    logic [1:0] pair;
    logic       pick_hi;

    assign cur = tree_q[set_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[set_idx][0] <= ~touch_way[1];  // point away from touched half
            if (touch_way[1]) begin
                tree_q[set_idx][2] <= ~touch_way[0];
            end else begin
                tree_q[set_idx][1] <= ~touch_way[0];
            end
        end
    end

    // the walk follows the tree bits but never leaves the allowed group
    always_comb begin
        go_right = (|group[3:2]) && (!(|group[1:0]) || cur[0]);
        pair     = go_right ? group[3:2] : group[1:0];
        pick_hi  = pair[1] && (!pair[0] || (go_right ? cur[2] : cur[1]));
        victim   = {go_right, pick_hi};
    end

endmodule

//--- rtl/way_lookup.sv
`include "cache_settings.svh"

module way_lookup (
    input  cache_ctrl_pkg::assoc_mode_t mode,
    input  cache_geom_pkg::tag_t        req_tag,
    input  cache_geom_pkg::word_sel_t   word_sel,
    input  cache_geom_pkg::line_t       way_data [`CACHE_WAYS],
    input  cache_geom_pkg::tag_t        way_tag [`CACHE_WAYS],
    input  cache_geom_pkg::way_vec_t    way_valid,
    output logic                        hit,
    output cache_geom_pkg::way_idx_t    hit_way,
    output cache_geom_pkg::way_vec_t    group,
    output cache_geom_pkg::word_t       rdata
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    way_vec_t match;

    // the pair in TWO_WAY mode always holds the DIRECT way of the same tag
    always_comb begin
        case (mode)
            DIRECT:  group = way_vec_t'(1) << req_tag[1:0];
            TWO_WAY: group = {{2{req_tag[1]}}, {2{~req_tag[1]}}};
            default: group = '1;
        endcase
    end

    always_comb begin
        match   = '0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = group[w] && way_valid[w] && (way_tag[w] == req_tag);  // full tag
            if (match[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit   = |match;
    assign rdata = way_data[hit_way][word_sel*$bits(word_t) +: $bits(word_t)];

endmodule

//--- rtl/way_store.sv
`include "cache_settings.svh"

module way_store (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_geom_pkg::set_idx_t   set_idx,
    input  cache_geom_pkg::way_vec_t   line_we,
    input  cache_geom_pkg::line_mask_t line_wmask,
    input  cache_geom_pkg::line_t      line_wdata,
    input  cache_geom_pkg::tag_t       tag_wdata,
    input  logic                       dirty_wdata,
    output cache_geom_pkg::line_t      way_data [`CACHE_WAYS],
    output cache_geom_pkg::tag_t       way_tag [`CACHE_WAYS],
    output cache_geom_pkg::way_vec_t   way_valid,
    output cache_geom_pkg::way_vec_t   way_dirty
);
    import cache_geom_pkg::*;

    line_t    data_mem [`CACHE_WAYS][`CACHE_SETS];
    tag_t     tag_mem [`CACHE_WAYS][`CACHE_SETS];
    way_vec_t valid_q [`CACHE_SETS];  // one bit per way
    way_vec_t dirty_q [`CACHE_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (line_we[w]) begin
                for (int b = 0; b < `LINE_BYTES; b++) begin
                    if (line_wmask[b]) begin
                        data_mem[w][set_idx][b*8 +: 8] <= line_wdata[b*8 +: 8];  // byte merge
                    end
                end
                tag_mem[w][set_idx] <= tag_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (line_we[w]) begin
                    valid_q[set_idx][w] <= 1'b1;
                    dirty_q[set_idx][w] <= dirty_wdata;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_data[w] = data_mem[w][set_idx];  // async read at latched set
            way_tag[w]  = tag_mem[w][set_idx];
        end
    end

    assign way_valid = valid_q[set_idx];
    assign way_dirty = dirty_q[set_idx];

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mutative_cache -f all.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_mutative_cache +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0
